//--- common/clkdiv_config.svh
// ########################################
// clock divider bank configuration
// channel count, divisor range, reset hold
// and period counter width
// ########################################
`ifndef CLKDIV_CONFIG_SVH
`define CLKDIV_CONFIG_SVH

// number of divider channels
`define CLKDIV_NUM_CH   4
// largest divisor, also the ring length
`define CLKDIV_MAX_DIV  15
// divisor field width
`define CLKDIV_DIV_W    4
// clk cycles a channel is held in reset after a write
`define CLKDIV_RST_HOLD 2
// period counter width, saturates well above max divisor
`define CLKDIV_PER_W    5

`endif

//--- common/clkdiv_pkg.sv
// ########################################
// clock divider bank types
// write request, live channel config and
// period report structs
// ########################################
`include "clkdiv_config.svh"

package clkdiv_pkg;

   // single-cycle write strobe from outside
   typedef struct packed {
      logic                              valid;
      // target channel
      logic [$clog2(`CLKDIV_NUM_CH)-1:0] ch;
      // divisor, 0 or 1 turns the channel off
      logic [`CLKDIV_DIV_W-1:0]          div;
   } cfg_wr_t;

   // live configuration of one divider channel
   typedef struct packed {
      logic [`CLKDIV_DIV_W-1:0] div;
      // local reset, held low after a change and while disabled
      logic                     ch_rst_b;
   } ch_cfg_t;

   // period report of one channel
   typedef struct packed {
      // one-cycle strobe
      logic                     valid;
      // clk cycles between successive rising edges
      logic [`CLKDIV_PER_W-1:0] period;
   } meas_t;

   // one entry per channel
   typedef ch_cfg_t [`CLKDIV_NUM_CH-1:0] ch_cfg_vec_t;
   typedef meas_t   [`CLKDIV_NUM_CH-1:0] meas_vec_t;

endpackage

//--- clkdiv/clkdiv_ring.sv
// ########################################
// clkdiv_ring
// ring-shift clock divider for divisors
// 2..MAX_DIV with a falling edge half stage
// that gives odd divisors near 50% duty
// ########################################
`timescale 1ns/100ps
`include "clkdiv_config.svh"

module clkdiv_ring (
   input  logic                clk,
   input  logic                rst_b,
   input  clkdiv_pkg::ch_cfg_t cfg,
   output logic                div_clk
);

   localparam int MAX = `CLKDIV_MAX_DIV;

   // upper ring bits only since bit 0 lives in its own toggle stage
   logic [MAX-1:1] ring_q;
   logic           bit0_q;
   logic [MAX-1:0] ring_cur;
   logic [MAX-1:0] ring_rot;
   logic [MAX-1:0] ring_nxt;
   logic [MAX-1:0] ring_init;
   logic           bit0_tgl;
   // half-cycle delayed copy of bit 0
   logic           neg_q;

   assign ring_cur = {ring_q, bit0_q};

   // rotate one step toward bit 0
   assign ring_rot = {ring_cur[0], ring_cur[MAX-1:1]};

   // recirculate bit 0 into position div-1 so the loop is div long
   always_comb begin
      for (int i = 0; i < MAX; i++) begin
         if (i == int'(cfg.div) - 1)
            ring_nxt[i] = ring_cur[0];
         else if (i < int'(cfg.div) - 1)
            ring_nxt[i] = ring_rot[i];
         else
            ring_nxt[i] = 1'b0;
      end
   end

   // preload sets bits 1..div/2 high and the rest low
   // bit 0 starts low so the first rise comes one step after release
   always_comb begin
      for (int i = 0; i < MAX; i++) begin
         ring_init[i] = (i >= 1) && (i <= int'(cfg.div >> 1));
      end
   end

   // toggle stage flips only when the ring presents a new level
   assign bit0_tgl = ring_nxt[0] ^ bit0_q;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         ring_q <= '0;
         bit0_q <= 1'b0;
      end else if (!cfg.ch_rst_b) begin
         // divisor only changes while the channel sits here
         ring_q <= ring_init[MAX-1:1];
         bit0_q <= ring_init[0];
      end else begin
         ring_q <= ring_nxt[MAX-1:1];
         bit0_q <= bit0_q ^ bit0_tgl;
      end
   end

   // falling edge stage delays bit 0 by half a clk
   always_ff @(negedge clk or negedge rst_b) begin
      if (!rst_b)
         neg_q <= 1'b0;
      else if (!cfg.ch_rst_b)
         neg_q <= 1'b0;
      else
         neg_q <= bit0_q;
   end

   // odd divisor stretches the high phase by half a cycle
   assign div_clk = bit0_q | (neg_q & cfg.div[0]);

endmodule

//--- verilog/clkdiv_cfg_regs.sv
// ########################################
// clkdiv_cfg_regs
// per-channel divisor registers written by
// strobe, holds a channel in local reset
// after each change and while disabled
// ########################################
`timescale 1ns/100ps
`include "clkdiv_config.svh"

module clkdiv_cfg_regs (
   input  logic                    clk,
   input  logic                    rst_b,
   input  clkdiv_pkg::cfg_wr_t     wr,
   output clkdiv_pkg::ch_cfg_vec_t ch_cfg
);

   localparam int NUM_CH = `CLKDIV_NUM_CH;
   localparam int CH_W   = $clog2(`CLKDIV_NUM_CH);
   localparam int DIV_W  = `CLKDIV_DIV_W;
   localparam int HOLD_W = $clog2(`CLKDIV_RST_HOLD + 1);
   localparam logic [HOLD_W-1:0] HOLD_LOAD = HOLD_W'(`CLKDIV_RST_HOLD);

   // stored divisor per channel
   logic [DIV_W-1:0]  div_q  [NUM_CH];
   // divisor of 2 or more
   logic [NUM_CH-1:0] en_q;
   // registered local reset, active low
   logic [NUM_CH-1:0] rst_b_q;
   // reset hold countdown
   logic [HOLD_W-1:0] hold_q [NUM_CH];
   // write addressed to channel i
   logic [NUM_CH-1:0] hit;

   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         hit[i] = wr.valid && (wr.ch == CH_W'(i));
      end
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         // all channels come up off, divisor 0
         for (int i = 0; i < NUM_CH; i++) begin
            div_q[i]   <= '0;
            en_q[i]    <= 1'b0;
            rst_b_q[i] <= 1'b0;
            hold_q[i]  <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_CH; i++) begin
            if (hit[i]) begin
               div_q[i]   <= wr.div;
               // the one place below-2 becomes disable
               en_q[i]    <= (wr.div >= DIV_W'(2));
               rst_b_q[i] <= 1'b0;
               hold_q[i]  <= HOLD_LOAD;
            end else if (hold_q[i] != '0) begin
               hold_q[i]  <= hold_q[i] - 1'b1;
               // release on the last hold cycle, unless disabled
               rst_b_q[i] <= (hold_q[i] == HOLD_W'(1)) && en_q[i];
            end else begin
               rst_b_q[i] <= en_q[i];
            end
         end
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         ch_cfg[i].div      = div_q[i];
         ch_cfg[i].ch_rst_b = rst_b_q[i];
      end
   end

endmodule

//--- verilog/clkdiv_period_meter.sv
// ########################################
// clkdiv_period_meter
// samples each divided clock in the clk
// domain and reports clk cycles between
// successive rising edges as strobes
// ########################################
`timescale 1ns/100ps
`include "clkdiv_config.svh"

module clkdiv_period_meter (
   input  logic                        clk,
   input  logic                        rst_b,
   input  logic [`CLKDIV_NUM_CH-1:0]   div_clk,
   input  clkdiv_pkg::ch_cfg_vec_t     ch_cfg,
   output clkdiv_pkg::meas_vec_t       meas
);

   localparam int NUM_CH = `CLKDIV_NUM_CH;
   localparam int PER_W  = `CLKDIV_PER_W;
   localparam logic [PER_W-1:0] PER_MAX = '1;

   // sampler, first stage takes the divided clock
   logic [NUM_CH-1:0] samp_q;
   // previous sampled value
   logic [NUM_CH-1:0] prev_q;
   logic [NUM_CH-1:0] rise;
   // first rise after channel reset seen
   logic [NUM_CH-1:0] armed_q;
   // clk cycles since last rise
   logic [PER_W-1:0]  cnt_q [NUM_CH];
   // report registers
   logic [NUM_CH-1:0] valid_q;
   logic [PER_W-1:0]  per_q [NUM_CH];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         samp_q <= '0;
         prev_q <= '0;
      end else begin
         samp_q <= div_clk;
         prev_q <= samp_q;
      end
   end

   assign rise = samp_q & ~prev_q;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         armed_q <= '0;
         valid_q <= '0;
         for (int i = 0; i < NUM_CH; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_CH; i++) begin
            if (!ch_cfg[i].ch_rst_b) begin
               // channel in local reset, forget history
               armed_q[i] <= 1'b0;
               valid_q[i] <= 1'b0;
               cnt_q[i]   <= '0;
            end else if (rise[i]) begin
               // first rise only arms
               armed_q[i] <= 1'b1;
               valid_q[i] <= armed_q[i];
               // count starts at 1 so a rise div cycles later reads div
               cnt_q[i]   <= PER_W'(1);
            end else begin
               valid_q[i] <= 1'b0;
               if (cnt_q[i] != PER_MAX)
                  cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   // period payload, captured on every rise
   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_CH; i++) begin
         if (rise[i])
            per_q[i] <= cnt_q[i];
      end
   end

   always_comb begin
      for (int i = 0; i < NUM_CH; i++) begin
         meas[i].valid  = valid_q[i];
         meas[i].period = per_q[i];
      end
   end

endmodule

//--- verilog/clkdiv_bank_top.sv
// ########################################
// clkdiv_bank_top
// bank of programmable clock dividers:
// register block, divider channels and
// period meter
// ########################################
`timescale 1ns/100ps
`include "clkdiv_config.svh"

module clkdiv_bank_top (
   input  logic                  clk,
   input  logic                  rst_b,
   input  clkdiv_pkg::cfg_wr_t   wr,
   output clkdiv_pkg::meas_vec_t meas
);

   import clkdiv_pkg::*;

   // live per-channel divisor and local reset
   ch_cfg_vec_t                ch_cfg;
   // one divided clock per channel
   logic [`CLKDIV_NUM_CH-1:0] div_clk;

   clkdiv_cfg_regs clkdiv_cfg_regs_i (
      .clk    (clk),
      .rst_b  (rst_b),
      .wr     (wr),
      .ch_cfg (ch_cfg)
   );

   // one ring divider per channel
   for (genvar i = 0; i < `CLKDIV_NUM_CH; i++) begin : g_ch
      clkdiv_ring clkdiv_ring_i (
         .clk     (clk),
         .rst_b   (rst_b),
         .cfg     (ch_cfg[i]),
         .div_clk (div_clk[i])
      );
   end

   // meter uses the local resets to drop stale edges
   clkdiv_period_meter clkdiv_period_meter_i (
      .clk     (clk),
      .rst_b   (rst_b),
      .div_clk (div_clk),
      .ch_cfg  (ch_cfg),
      .meas    (meas)
   );

endmodule

//--- test/clkdiv_bank_checker.sv
// ########################################
// clkdiv_bank_checker
// watches writes and period reports, keeps
// a divisor model per channel and counts
// wrong periods, stray reports and stalls
// ########################################
`timescale 1ns/100ps
`include "clkdiv_config.svh"

module clkdiv_bank_checker (
   input  logic                  clk,
   input  logic                  rst_b,
   input  clkdiv_pkg::cfg_wr_t   wr,
   input  clkdiv_pkg::meas_vec_t meas,
   output int                    error_count,
   output int                    report_count,
   output int                    even_count,
   output int                    odd_count,
   output int                    write_count,
   output logic                  busy
);

   import clkdiv_pkg::*;

   localparam int NUM_CH    = `CLKDIV_NUM_CH;
   localparam int MAX_DIV   = `CLKDIV_MAX_DIV;
   localparam int HOLD      = `CLKDIV_RST_HOLD;
   // first report must arrive within this many cycles after the hold
   localparam int STALL_LIM = 3 * MAX_DIV + 10;

   // divisor the channel currently runs with, 0 or 1 means off
   int model_div [NUM_CH];
   // divisor of a write still inside its hold window
   int pend_div  [NUM_CH];
   int pend_cnt  [NUM_CH];
   // cycles left for the first report after a reprogram
   int wait_cnt  [NUM_CH];

   int err_cnt  = 0;
   int rep_cnt  = 0;
   int even_cnt = 0;
   int odd_cnt  = 0;
   int wr_cnt   = 0;

   assign error_count  = err_cnt;
   assign report_count = rep_cnt;
   assign even_count   = even_cnt;
   assign odd_count    = odd_cnt;
   assign write_count  = wr_cnt;

   always_comb begin
      busy = 1'b0;
      for (int i = 0; i < NUM_CH; i++) begin
         if (pend_cnt[i] != 0 || wait_cnt[i] != 0)
            busy = 1'b1;
      end
   end

   // sample mid-cycle, away from the rising edge where everything moves
   always @(negedge clk) begin
      if (!rst_b) begin
         for (int i = 0; i < NUM_CH; i++) begin
            model_div[i] = 0;
            pend_div[i]  = 0;
            pend_cnt[i]  = 0;
            wait_cnt[i]  = 0;
            // no channel may report while in reset
            if (meas[i].valid) begin
               err_cnt++;
               $display("Error %0t: channel %0d reported during reset", $time, i);
            end
         end
      end else begin
         for (int i = 0; i < NUM_CH; i++) begin
            if (pend_cnt[i] != 0) begin
               // hold window, reports here may carry the old divisor
               pend_cnt[i]--;
               if (pend_cnt[i] == 0) begin
                  model_div[i] = pend_div[i];
                  wait_cnt[i]  = (model_div[i] >= 2) ? STALL_LIM : 0;
               end
            end else if (meas[i].valid) begin
               rep_cnt++;
               wait_cnt[i] = 0;
               if (model_div[i] < 2) begin
                  err_cnt++;
                  $display("Error %0t: channel %0d reported period %0d while disabled",
                           $time, i, meas[i].period);
               end else if (int'(meas[i].period) != model_div[i]) begin
                  err_cnt++;
                  $display("Error %0t: channel %0d reported period %0d, expected %0d",
                           $time, i, meas[i].period, model_div[i]);
               end else if (model_div[i] % 2 == 0) begin
                  even_cnt++;
               end else begin
                  odd_cnt++;
               end
            end else if (wait_cnt[i] != 0) begin
               wait_cnt[i]--;
               if (wait_cnt[i] == 0) begin
                  err_cnt++;
                  $display("channel %0d stalled at %0t, no report within %0d cycles %s",
                           i, $time, STALL_LIM, "after it was reprogrammed");
               end
            end
         end
         // new write opens the hold window of its channel
         if (wr.valid) begin
            wr_cnt++;
            pend_div[wr.ch] = int'(wr.div);
            pend_cnt[wr.ch] = HOLD;
            wait_cnt[wr.ch] = 0;
         end
      end
   end

endmodule

//--- test/clkdiv_bank_tb.sv
// ########################################
// clkdiv_bank_tb
// drives seeded random divisor writes into
// the clock divider bank while a checker
// compares the period reports to its model
// ########################################
`timescale 1ns/100ps
`include "clkdiv_config.svh"

module clkdiv_bank_tb;

   import clkdiv_pkg::*;

   localparam int    NUM_CH     = `CLKDIV_NUM_CH;
   localparam int    MAX_DIV    = `CLKDIV_MAX_DIV;
   localparam time   CLK_PERIOD = 40ns;
   localparam int    RST_CYC    = 8;
   localparam int    SEED       = 81;
   localparam int    N_WR       = 40;
   localparam int    GAP_MIN    = 150;
   localparam int    GAP_MAX    = 300;
   // quiet stretch after reset where no channel may report
   localparam int    IDLE_CYC   = 50;
   localparam int    TIMEOUT    = N_WR * GAP_MAX + 500;

   logic      clk;
   logic      rst_b;
   cfg_wr_t   wr;
   meas_vec_t meas;

   int   error_count;
   int   report_count;
   int   even_count;
   int   odd_count;
   int   write_count;
   logic busy;
   int   cycle_count;

   clkdiv_bank_top clkdiv_bank_top_i (
      .clk   (clk),
      .rst_b (rst_b),
      .wr    (wr),
      .meas  (meas)
   );

   clkdiv_bank_checker clkdiv_bank_checker_i (
      .clk          (clk),
      .rst_b        (rst_b),
      .wr           (wr),
      .meas         (meas),
      .error_count  (error_count),
      .report_count (report_count),
      .even_count   (even_count),
      .odd_count    (odd_count),
      .write_count  (write_count),
      .busy         (busy)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // run limit counted in clk cycles from time 0
   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
      $display("ERRORS FOUND");
      $finish;
   end

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   // one-cycle write strobe
   task automatic issue_write(input int ch, input int div);
      cfg_wr_t w;
      w       = '0;
      w.valid = 1'b1;
      w.ch    = ch[$bits(w.ch)-1:0];
      w.div   = div[$bits(w.div)-1:0];
      @(posedge clk);
      wr <= w;
      @(posedge clk);
      wr <= '0;
   endtask

   initial begin
      int seed_ret;
      int ch;
      int div;
      int gap;
      bit failed;
      seed_ret = $urandom(SEED);
      rst_b    = 1'b0;
      wr       = '0;
      wait_cycles(RST_CYC);
      rst_b <= 1'b1;
      wait_cycles(IDLE_CYC);

      for (int n = 0; n < N_WR; n++) begin
         ch  = $urandom_range(NUM_CH - 1, 0);
         div = $urandom_range(MAX_DIV, 0);
         issue_write(ch, div);
         gap = $urandom_range(GAP_MAX, GAP_MIN);
         wait_cycles(gap);
      end

      // let the checker close any open hold or first-report window
      wait_cycles(2);
      while (busy)
         @(posedge clk);

      failed = (error_count != 0);
      if (write_count != N_WR) begin
         $display("the checker saw %0d writes instead of %0d", write_count, N_WR);
         failed = 1'b1;
      end
      if (report_count == 0) begin
         $display("no period report was checked during the whole run");
         failed = 1'b1;
      end
      if (even_count == 0) begin
         $display("no report of an even divisor was checked");
         failed = 1'b1;
      end
      if (odd_count == 0) begin
         $display("no report of an odd divisor was checked");
         failed = 1'b1;
      end
      $display("writes %0d reports %0d even %0d odd %0d errors %0d",
               write_count, report_count, even_count, odd_count, error_count);
      if (!failed)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

//--- clkdiv_bank.f
+incdir+common
common/clkdiv_pkg.sv
clkdiv/clkdiv_ring.sv
verilog/clkdiv_cfg_regs.sv
verilog/clkdiv_period_meter.sv
verilog/clkdiv_bank_top.sv
test/clkdiv_bank_checker.sv
test/clkdiv_bank_tb.sv
